//--- source/rtx_pkg.sv
`default_nettype none

package rtx_pkg;

  // render target
  localparam int FB_WIDTH = 32;
  localparam int FB_HEIGHT = 16;
  localparam int FB_ADDR_BITS = 9;   // row * FB_WIDTH + col

  // scene
  localparam int SCENE_DEPTH = 8;
  localparam int OBJ_IDX_BITS = 3;

  // flash stream
  localparam int PAYLOAD_BYTES = 8;  // data bytes after cam / obj command

  localparam int COORD_BITS = 8;     // world coords, wrap mod 256

  // opcode lives in bits 7:6 of the command byte
  typedef enum logic [1:0] {
    OP_NONE   = 2'b00,  // ignored
    OP_CAM    = 2'b01,
    OP_OBJ    = 2'b10,
    OP_RENDER = 2'b11
  } flash_op_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WALK,   // issue objects, then drain
    ST_EMIT,   // pixel offered to writer
    ST_DONE    // wait for last bus ack
  } ctrl_state_t;

  typedef logic [15:0] rgb565_t;

  // 64 bit payload image, msb first on the wire
  typedef struct packed {
    logic [7:0]            rsvd;   // top byte unused
    logic [COORD_BITS-1:0] x0;
    logic [COORD_BITS-1:0] x1;
    logic [COORD_BITS-1:0] y0;
    logic [COORD_BITS-1:0] y1;
    logic [7:0]            depth;  // 0 = empty slot, lower = nearer
    rgb565_t               color;
  } object_t;

  typedef struct packed {
    logic [COORD_BITS-1:0] pan_x;
    logic [COORD_BITS-1:0] pan_y;
    rgb565_t               bg_color;
  } camera_t;

endpackage

`default_nettype wire

//--- source/flash_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded flash command, one strobe per finished command
interface flash_if;

  logic                              wen;   // single cycle
  rtx_pkg::flash_op_t                op;
  logic [rtx_pkg::OBJ_IDX_BITS-1:0]  idx;   // object slot
  logic [8*rtx_pkg::PAYLOAD_BYTES-1:0] data;

  // parser side
  modport source (output wen, op, idx, data);

  // control and scene buffer
  modport sink (input wen, op, idx, data);

endinterface

`default_nettype wire

//--- source/pixel_if.sv
`timescale 1ns/1ps
`default_nettype none

// valid / ready pixel handoff, transfer when both high
interface pixel_if;

  logic                              valid;
  logic                              ready;
  logic [rtx_pkg::FB_ADDR_BITS-1:0]  addr;   // row major
  rtx_pkg::rgb565_t                  color;

  // addr and color held while valid waits on ready
  modport source (output valid, addr, color, input ready);

  modport sink (input valid, addr, color, output ready);

endinterface

`default_nettype wire

//--- source/uart_memflash.sv
`timescale 1ns/1ps
`default_nettype none

module uart_memflash (
  input  logic       clk_rtx,
  input  logic       sys_rst,
  input  logic       rx_valid,      // one received byte
  input  logic [7:0] rx_byte,
  output logic       flash_active,  // high while payload bytes expected
  flash_if.source    flash
);
  import rtx_pkg::*;

  flash_op_t                        cmd_op;    // opcode of incoming byte
  flash_op_t                        op_q;
  logic [OBJ_IDX_BITS-1:0]          idx_q;
  logic [$clog2(PAYLOAD_BYTES)-1:0] byte_cnt;  // payload bytes taken so far
  logic [8*PAYLOAD_BYTES-1:0]       payload;
  logic                             wen_q;

  assign cmd_op = flash_op_t'(rx_byte[7:6]);

  // command / payload sequencing
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      flash_active <= 1'b0;
      wen_q <= 1'b0;
      op_q <= OP_NONE;
      byte_cnt <= '0;
    end else begin
      wen_q <= 1'b0;  // strobe
      if (rx_valid) begin
        if (flash_active) begin
          byte_cnt <= byte_cnt + 1'b1;
          if (int'(byte_cnt) == PAYLOAD_BYTES - 1) begin
            flash_active <= 1'b0;  // last byte in
            wen_q <= 1'b1;         // strobe lands one cycle later
          end
        end else begin
          case (cmd_op)
            OP_CAM, OP_OBJ: begin
              flash_active <= 1'b1;
              op_q <= cmd_op;
              byte_cnt <= '0;
            end
            OP_RENDER: begin
              op_q <= OP_RENDER;  // no payload, fire right away
              wen_q <= 1'b1;
            end
            default: ;  // opcode 00 dropped
          endcase
        end
      end
    end
  end

  // payload shifts in msb first
  always_ff @(posedge clk_rtx) begin
    if (rx_valid) begin
      if (flash_active) begin
        payload <= {payload[8*PAYLOAD_BYTES-9:0], rx_byte};
      end else begin
        idx_q <= rx_byte[OBJ_IDX_BITS-1:0];  // only meaningful for obj
      end
    end
  end

  assign flash.wen  = wen_q;
  assign flash.op   = op_q;
  assign flash.idx  = idx_q;
  assign flash.data = payload;

  // a strobe only follows a finished command
  a_wen_not_active: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    !(flash.wen && flash_active));

endmodule

`default_nettype wire

//--- source/scene_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module scene_buffer (
  input  logic                             clk_rtx,
  input  logic                             sys_rst,
  flash_if.sink                            flash,
  input  logic [rtx_pkg::OBJ_IDX_BITS-1:0] obj_idx,
  output rtx_pkg::object_t                 obj      // one cycle after obj_idx
);
  import rtx_pkg::*;

  object_t mem [SCENE_DEPTH];

  // flash write port, all slots empty after reset
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      for (int i = 0; i < SCENE_DEPTH; i++) begin
        mem[i] <= '0;  // depth 0 = empty
      end
    end else if (flash.wen && flash.op == OP_OBJ) begin
      mem[flash.idx] <= object_t'(flash.data);
    end
  end

  // registered read, sees a write from the previous cycle
  always_ff @(posedge clk_rtx) begin
    obj <= mem[obj_idx];
  end

endmodule

`default_nettype wire

//--- source/depth_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module depth_resolve (
  input  logic                           clk_rtx,
  input  logic                           sys_rst,
  input  logic                           clear,      // start of a new pixel
  input  logic                           check,      // obj valid this cycle
  input  logic [rtx_pkg::COORD_BITS-1:0] wx,
  input  logic [rtx_pkg::COORD_BITS-1:0] wy,
  input  rtx_pkg::object_t               obj,
  output logic                           hit,
  output rtx_pkg::rgb565_t               hit_color
);

  logic [7:0] best_depth;  // depth of held hit
  logic       covers;
  logic       nearer;

  // inclusive bounds, empty slots never cover
  assign covers = (obj.depth != 8'd0) &&
                  (wx >= obj.x0) && (wx <= obj.x1) &&
                  (wy >= obj.y0) && (wy <= obj.y1);

  // strictly lower depth only, so a tie keeps the earlier index
  assign nearer = !hit || (obj.depth < best_depth);

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      hit <= 1'b0;
    end else if (clear) begin
      hit <= 1'b0;
    end else if (check && covers) begin
      hit <= 1'b1;  // sticky within a pixel
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (!clear && check && covers && nearer) begin
      best_depth <= obj.depth;
      hit_color <= obj.color;
    end
  end

endmodule

`default_nettype wire

//--- source/render_control.sv
`timescale 1ns/1ps
`default_nettype none

module render_control (
  input  logic                             clk_rtx,
  input  logic                             sys_rst,
  input  logic                             mem_ready,
  flash_if.sink                            flash,
  output logic [rtx_pkg::OBJ_IDX_BITS-1:0] obj_idx,
  output logic                             dr_clear,
  output logic                             dr_check,
  output logic [rtx_pkg::COORD_BITS-1:0]   wx,
  output logic [rtx_pkg::COORD_BITS-1:0]   wy,
  input  logic                             hit,
  input  rtx_pkg::rgb565_t                 hit_color,
  input  logic                             last_ack,   // ack of final pixel
  pixel_if.source                          pix,
  output logic                             busy,
  output logic                             frame_done
);
  import rtx_pkg::*;

  ctrl_state_t                       state;
  camera_t                           cam;
  logic                              mem_seen;   // sticky
  logic                              start;
  logic [$clog2(SCENE_DEPTH+2)-1:0]  walk_cnt;   // issue slots then 2 drain
  logic [$clog2(FB_WIDTH)-1:0]       col;
  logic [$clog2(FB_HEIGHT)-1:0]      row;
  logic                              last_pix;
  logic                              walk_end;   // hit final this cycle
  rgb565_t                           pix_color;

  assign start = flash.wen && (flash.op == OP_RENDER) && (state == ST_IDLE) &&
                 (mem_seen || mem_ready);
  assign last_pix = (int'(col) == FB_WIDTH - 1) && (int'(row) == FB_HEIGHT - 1);
  assign walk_end = (state == ST_WALK) && (int'(walk_cnt) == SCENE_DEPTH + 1);

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      mem_seen <= 1'b0;
      cam <= '0;  // no pan, black bg
    end else begin
      mem_seen <= mem_seen | mem_ready;
      if (flash.wen && flash.op == OP_CAM) begin
        cam <= camera_t'(flash.data[$bits(camera_t)-1:0]);
      end
    end
  end

  // pixel scan and object walk
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state <= ST_IDLE;
      walk_cnt <= '0;
      col <= '0;
      row <= '0;
      dr_check <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      // scene read has one cycle latency, check trails the issue
      dr_check <= (state == ST_WALK) && (int'(walk_cnt) < SCENE_DEPTH);
      frame_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_WALK;
            walk_cnt <= '0;
            col <= '0;
            row <= '0;
          end
        end
        ST_WALK: begin
          walk_cnt <= walk_cnt + 1'b1;
          if (walk_end) state <= ST_EMIT;
        end
        ST_EMIT: begin
          if (pix.ready) begin
            walk_cnt <= '0;
            if (last_pix) begin
              state <= ST_DONE;
            end else begin
              state <= ST_WALK;
              col <= col + 1'b1;  // wraps at row end
              if (int'(col) == FB_WIDTH - 1) row <= row + 1'b1;
            end
          end
        end
        ST_DONE: begin
          if (frame_done) state <= ST_IDLE;  // busy drops after the pulse
          else if (last_ack) frame_done <= 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // color frozen for the whole emit
  always_ff @(posedge clk_rtx) begin
    if (walk_end) pix_color <= hit ? hit_color : cam.bg_color;
  end

  assign obj_idx = walk_cnt[OBJ_IDX_BITS-1:0];  // drain slots reread, unused
  assign dr_clear = (state == ST_WALK) && (walk_cnt == '0);
  assign wx = cam.pan_x + COORD_BITS'(col);  // mod 256
  assign wy = cam.pan_y + COORD_BITS'(row);

  assign pix.valid = (state == ST_EMIT);
  assign pix.addr = {row, col};
  assign pix.color = pix_color;

  assign busy = (state != ST_IDLE);

  a_pix_hold: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    pix.valid && !pix.ready |=> pix.valid && $stable(pix.addr) && $stable(pix.color));

  // done pulse lands inside the frame
  a_done_in_busy: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    frame_done |-> busy);

endmodule

`default_nettype wire

//--- source/pixel_writer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_writer (
  input  logic                             clk_rtx,
  input  logic                             sys_rst,
  pixel_if.sink                            pix,
  output logic                             wb_cyc,
  output logic                             wb_stb,
  output logic                             wb_we,
  output logic [rtx_pkg::FB_ADDR_BITS-1:0] wb_adr,
  output rtx_pkg::rgb565_t                 wb_dat_o,
  input  logic                             wb_ack,
  output logic                             last_ack  // final pixel acked
);
  import rtx_pkg::*;

  logic bus_busy;  // one classic cycle in flight

  assign pix.ready = !bus_busy;  // take a pixel only when idle

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      bus_busy <= 1'b0;
    end else if (bus_busy) begin
      if (wb_ack) bus_busy <= 1'b0;  // release next edge
    end else if (pix.valid) begin
      bus_busy <= 1'b1;
    end
  end

  // latch on transfer, stays put until ack
  always_ff @(posedge clk_rtx) begin
    if (pix.valid && pix.ready) begin
      wb_adr <= pix.addr;
      wb_dat_o <= pix.color;
    end
  end

  assign wb_cyc = bus_busy;
  assign wb_stb = bus_busy;
  assign wb_we = 1'b1;  // write only port

  assign last_ack = bus_busy && wb_ack &&
                    (wb_adr == FB_ADDR_BITS'(FB_WIDTH * FB_HEIGHT - 1));

  a_wb_stable: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_o));

endmodule

`default_nettype wire

//--- source/rtx_top.sv
`timescale 1ns/1ps
`default_nettype none

module rtx_top (
  input  logic                             clk_rtx,
  input  logic                             sys_rst,
  input  logic                             mem_ready,   // frame buffer up
  input  logic                             rx_valid,
  input  logic [7:0]                       rx_byte,
  output logic                             flash_active,
  output logic                             busy,
  output logic                             frame_done,
  output logic                             wb_cyc,
  output logic                             wb_stb,
  output logic                             wb_we,
  output logic [rtx_pkg::FB_ADDR_BITS-1:0] wb_adr,
  output logic [15:0]                      wb_dat_o,
  input  logic                             wb_ack
);
  import rtx_pkg::*;

  flash_if flash_bus ();
  pixel_if pix_bus ();

  logic [OBJ_IDX_BITS-1:0] obj_idx;
  object_t                 obj;
  logic                    dr_clear;
  logic                    dr_check;
  logic [COORD_BITS-1:0]   wx;
  logic [COORD_BITS-1:0]   wy;
  logic                    hit;
  rgb565_t                 hit_color;
  logic                    last_ack;

  uart_memflash u_flash (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst),
    .rx_valid(rx_valid), .rx_byte(rx_byte),
    .flash_active(flash_active), .flash(flash_bus.source)
  );

  scene_buffer u_scene (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst), .flash(flash_bus.sink),
    .obj_idx(obj_idx), .obj(obj)
  );

  depth_resolve u_depth (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst),
    .clear(dr_clear), .check(dr_check), .wx(wx), .wy(wy), .obj(obj),
    .hit(hit), .hit_color(hit_color)
  );

  render_control u_ctrl (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst), .mem_ready(mem_ready),
    .flash(flash_bus.sink), .obj_idx(obj_idx),
    .dr_clear(dr_clear), .dr_check(dr_check), .wx(wx), .wy(wy),
    .hit(hit), .hit_color(hit_color), .last_ack(last_ack),
    .pix(pix_bus.source), .busy(busy), .frame_done(frame_done)
  );

  pixel_writer u_writer (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst), .pix(pix_bus.sink),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
    .last_ack(last_ack)
  );

endmodule

`default_nettype wire

//--- testbench/tb_rtx_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rtx_top;
  import rtx_pkg::*;

  localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
  localparam int NUM_FRAMES = 5;      // frames rendered over all tests
  localparam int CYC_PER_PIXEL = 13;  // walk of 10 plus emit with slack
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FB_PIXELS * CYC_PER_PIXEL + 4000;
  localparam logic [31:0] RAND_SEED = 32'habdb6d6a;

  logic       clk_rtx;
  logic       sys_rst;
  logic       mem_ready;
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       flash_active;
  logic       busy;
  logic       frame_done;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [FB_ADDR_BITS-1:0] wb_adr;
  rgb565_t    wb_dat_o;
  logic       wb_ack = 1'b0;

  // frame buffer slave state
  rgb565_t fb_mem [FB_PIXELS];
  int      write_cnt [FB_PIXELS];  // running count per address
  int      base_cnt [FB_PIXELS];   // snapshot before a frame
  rgb565_t saved_img [FB_PIXELS];
  logic    rand_ack;               // 0 = ack in first cycle
  logic    in_cycle;
  int      ack_wait;
  logic    we_low_seen;
  logic    stb_split_seen;         // cyc and stb seen apart
  int      done_count;
  int      cycle_count;

  // reference copy of the scene
  logic [7:0] obj_x0 [SCENE_DEPTH];
  logic [7:0] obj_x1 [SCENE_DEPTH];
  logic [7:0] obj_y0 [SCENE_DEPTH];
  logic [7:0] obj_y1 [SCENE_DEPTH];
  logic [7:0] obj_depth [SCENE_DEPTH];
  rgb565_t    obj_color [SCENE_DEPTH];
  logic [7:0] pan_x_ref;
  logic [7:0] pan_y_ref;
  rgb565_t    bg_ref;

  int errors;
  int checks;
  int tests_run;

  rtx_top DUT (
    .clk_rtx(clk_rtx), .sys_rst(sys_rst), .mem_ready(mem_ready),
    .rx_valid(rx_valid), .rx_byte(rx_byte), .flash_active(flash_active),
    .busy(busy), .frame_done(frame_done),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
  );

  initial begin
    clk_rtx = 1'b0;
    forever #20 clk_rtx = ~clk_rtx;  // 40 ns period
  end

  // wishbone slave acks after 0..3 wait cycles
  always @(negedge clk_rtx) begin
    if (sys_rst) begin
      wb_ack <= 1'b0;
      in_cycle = 1'b0;
      ack_wait = 0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;  // master saw ack on the last edge
      in_cycle = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!in_cycle) begin
        in_cycle = 1'b1;
        ack_wait = rand_ack ? int'($urandom_range(3, 0)) : 0;
        if (wb_we !== 1'b1) we_low_seen = 1'b1;
      end
      if (ack_wait == 0) begin
        wb_ack <= 1'b1;
        fb_mem[wb_adr] = wb_dat_o;
        write_cnt[wb_adr]++;
      end else begin
        ack_wait--;
      end
    end
  end

  always @(negedge clk_rtx) begin
    if (!sys_rst && frame_done === 1'b1) done_count++;  // pulse counter
    if (!sys_rst && wb_cyc !== wb_stb) stb_split_seen = 1'b1;
  end

  always @(posedge clk_rtx) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the engine did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_color(input rgb565_t got, input rgb565_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // nearest nonzero depth wins and a strict compare keeps lower index on ties
  function automatic rgb565_t expected_pixel(input int addr);
    logic [7:0] wx;
    logic [7:0] wy;
    logic       found;
    logic [7:0] best;
    rgb565_t    color;
    wx = pan_x_ref + 8'(addr % FB_WIDTH);  // wraps mod 256
    wy = pan_y_ref + 8'(addr / FB_WIDTH);
    found = 1'b0;
    best = 8'd0;
    color = bg_ref;
    for (int i = 0; i < SCENE_DEPTH; i++) begin
      if (obj_depth[i] != 8'd0 && wx >= obj_x0[i] && wx <= obj_x1[i] &&
          wy >= obj_y0[i] && wy <= obj_y1[i] && (!found || obj_depth[i] < best)) begin
        found = 1'b1;
        best = obj_depth[i];
        color = obj_color[i];
      end
    end
    return color;
  endfunction

  // one byte per call with flash_active checked once it is taken
  task automatic send_byte(input logic [7:0] b, input logic exp_active);
    @(negedge clk_rtx);
    rx_valid = 1'b1;
    rx_byte = b;
    @(negedge clk_rtx);
    rx_valid = 1'b0;
    check_flag(flash_active, exp_active, $sformatf("flash_active after byte %h", b));
  endtask

  task automatic send_command(input logic [7:0] cmd, input logic [63:0] payload);
    send_byte(cmd, 1'b1);
    for (int i = PAYLOAD_BYTES - 1; i >= 0; i--) begin
      send_byte(payload[8*i +: 8], i != 0);  // msb first
    end
  endtask

  task automatic load_camera(input logic [7:0] px, input logic [7:0] py, input rgb565_t bg);
    send_command(8'h40, {32'h0, px, py, bg});
    pan_x_ref = px;
    pan_y_ref = py;
    bg_ref = bg;
  endtask

  task automatic load_object(input logic [2:0] idx, input logic [7:0] x0,
                             input logic [7:0] x1, input logic [7:0] y0,
                             input logic [7:0] y1, input logic [7:0] depth,
                             input rgb565_t color);
    send_command({5'b10000, idx}, {8'h00, x0, x1, y0, y1, depth, color});
    obj_x0[idx] = x0;
    obj_x1[idx] = x1;
    obj_y0[idx] = y0;
    obj_y1[idx] = y1;
    obj_depth[idx] = depth;
    obj_color[idx] = color;
  endtask

  // render one frame and check every address against the reference
  task automatic render_and_check(input string what);
    int done_before;
    for (int a = 0; a < FB_PIXELS; a++) base_cnt[a] = write_cnt[a];
    done_before = done_count;
    send_byte(8'hC0, 1'b0);
    @(negedge clk_rtx);  // strobe then walk start
    check_flag(busy, 1'b1, {what, " busy after render command"});
    while (frame_done !== 1'b1) @(negedge clk_rtx);  // until the done pulse
    @(negedge clk_rtx);
    check_flag(busy, 1'b0, {what, " busy after frame_done"});
    check_flag(frame_done, 1'b0, {what, " frame_done one cycle wide"});
    check_flag(wb_cyc, 1'b0, {what, " bus idle after frame"});
    check_flag(wb_stb, 1'b0, {what, " wb_stb idle after frame"});
    repeat (3) @(negedge clk_rtx);
    check_flag((done_count - done_before) == 1, 1'b1, {what, " frame_done pulsed once"});
    check_flag(we_low_seen, 1'b0, {what, " wb_we low during a cycle"});
    check_flag(stb_split_seen, 1'b0, {what, " wb_cyc and wb_stb apart"});
    for (int a = 0; a < FB_PIXELS; a++) begin
      if (write_cnt[a] - base_cnt[a] != 1) begin
        $display("CHECK FAILED at %0t: %s address %0d written %0d times expected 1",
                 $time, what, a, write_cnt[a] - base_cnt[a]);
        errors++;
      end
      check_color(fb_mem[a], expected_pixel(a), $sformatf("%s pixel %0d", what, a));
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err_before);
  endtask

  task automatic mem_ready_gate();
    int err_before;
    err_before = errors;
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(wb_cyc, 1'b0, "wb_cyc after reset");
    check_flag(wb_stb, 1'b0, "wb_stb after reset");
    check_flag(frame_done, 1'b0, "frame_done after reset");
    check_flag(flash_active, 1'b0, "flash_active after reset");
    send_byte(8'hC0, 1'b0);  // memory not up yet
    repeat (4) @(negedge clk_rtx);
    check_flag(busy, 1'b0, "busy with mem_ready low");
    check_flag(wb_cyc, 1'b0, "wb_cyc with mem_ready low");
    mem_ready = 1'b1;
    render_and_check("gate");  // empty scene on black bg
    report_test("mem_ready gate", err_before);
  endtask

  task automatic background_fill();
    int err_before;
    err_before = errors;
    load_camera(8'h00, 8'h00, 16'hA5C3);
    render_and_check("background");
    report_test("background fill", err_before);
  endtask

  task automatic depth_order();
    int err_before;
    err_before = errors;
    load_object(3'd0, 8'd2, 8'd10, 8'd2, 8'd8, 8'd20, 16'hF800);
    load_object(3'd1, 8'd5, 8'd15, 8'd4, 8'd12, 8'd10, 16'h07E0);   // nearer than 0
    load_object(3'd2, 8'd14, 8'd22, 8'd10, 8'd14, 8'd10, 16'h001F); // ties with 1
    load_object(3'd3, 8'd25, 8'd28, 8'd2, 8'd5, 8'd5, 16'hFFE0);
    load_object(3'd4, 8'd0, 8'd31, 8'd0, 8'd15, 8'd0, 16'hFFFF);    // empty slot
    load_object(3'd5, 8'd31, 8'd31, 8'd15, 8'd15, 8'd200, 16'h7BEF); // single pixel
    load_object(3'd6, 8'd20, 8'd18, 8'd0, 8'd15, 8'd1, 16'hF81F);   // inverted box
    load_object(3'd7, 8'd0, 8'd31, 8'd14, 8'd15, 8'd250, 16'h8410);
    render_and_check("depth");
    for (int a = 0; a < FB_PIXELS; a++) saved_img[a] = fb_mem[a];
    report_test("depth resolve", err_before);
  endtask

  task automatic pan_wrap();
    int err_before;
    err_before = errors;
    rand_ack = 1'b1;
    load_object(3'd6, 8'd244, 8'd255, 8'd250, 8'd255, 8'd3, 16'h39E7);
    load_camera(8'hF0, 8'hFC, 16'h0841);  // left and top edges wrap past 255
    render_and_check("pan");
    report_test("pan and wrap", err_before);
  endtask

  task automatic noop_and_ack_delay();
    int err_before;
    err_before = errors;
    send_byte(8'h3F, 1'b0);  // opcode 00
    send_byte(8'h07, 1'b0);
    repeat (3) @(negedge clk_rtx);
    check_flag(busy, 1'b0, "busy after opcode 00 bytes");
    load_camera(8'h00, 8'h00, 16'hA5C3);  // misaligns if 00 had been taken
    render_and_check("random ack");
    for (int a = 0; a < FB_PIXELS; a++) begin
      check_color(fb_mem[a], saved_img[a], $sformatf("random ack vs depth pixel %0d", a));
    end
    report_test("opcode 00 and ack delay", err_before);
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    sys_rst = 1'b1;
    mem_ready = 1'b0;
    rx_valid = 1'b0;
    rx_byte = 8'h00;
    rand_ack = 1'b0;
    we_low_seen = 1'b0;
    stb_split_seen = 1'b0;
    done_count = 0;
    cycle_count = 0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    pan_x_ref = 8'h00;
    pan_y_ref = 8'h00;
    bg_ref = 16'h0000;
    for (int i = 0; i < SCENE_DEPTH; i++) begin
      obj_x0[i] = 8'h00;
      obj_x1[i] = 8'h00;
      obj_y0[i] = 8'h00;
      obj_y1[i] = 8'h00;
      obj_depth[i] = 8'h00;  // matches cleared scene buffer
      obj_color[i] = 16'h0000;
    end
    for (int a = 0; a < FB_PIXELS; a++) begin
      fb_mem[a] = 16'h0000;
      write_cnt[a] = 0;
    end
    repeat (4) @(negedge clk_rtx);
    sys_rst = 1'b0;

    mem_ready_gate();
    background_fill();
    depth_order();
    pan_wrap();
    noop_and_ack_delay();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
source/rtx_pkg.sv
source/flash_if.sv
source/pixel_if.sv
source/uart_memflash.sv
source/scene_buffer.sv
source/depth_resolve.sv
source/render_control.sv
source/pixel_writer.sv
source/rtx_top.sv
testbench/tb_rtx_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_rtx_top -f tb.f -o sim_rtx

out=$(./obj_dir/sim_rtx || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
  exit 0
fi
exit 1
